//--- src.f
hw/mips_isa_pkg.sv
hw/ctrl_pkg.sv
hw/ctrl_if.sv
hw/control_fsm.sv
hw/instr_decoder.sv
hw/mem_lane_ctrl.sv
hw/mips_control.sv
bench/clk_gen.sv
bench/tb_mips_control.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status carries pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module tb_mips_control -o tb_mips_control

./obj_dir/tb_mips_control

//--- bench/tb_mips_control.sv
// Directed testbench running single instructions of the multicycle MIPS controller through every state
module tb_mips_control;

    import mips_isa_pkg::*;
    import ctrl_pkg::*;

    localparam int max_cycles = 2000;                 // About 40 instructions at worst-case stalls

    // Expected datapath controls of one instruction in exec1 and exec2
    typedef struct packed {
        alu_op_t   alu_op;
        logic      alu_src;
        logic      signed_imm;
        logic      jump;
        logic      branch;
        logic      reg_dst;
        logic      mem_to_reg;
        logic      writes;
        logic      reg_to_jump;
        logic      link;
        logic      reg_link;
        logic      load_imm;
        logic      is_load;
        logic      is_store;
        mem_size_t size;
        ext_op_t   ext_op;
    } controls_t;

    logic       clk;
    logic       reset;
    logic       run;
    logic       waitrequest;
    word_t      readdata;
    logic [1:0] addr_low;
    logic       ir_write;
    alu_op_t    alu_op;
    logic       alu_src;
    logic       signed_imm;
    logic       jump;
    logic       branch;
    logic       reg_dst;
    logic       mem_to_reg;
    logic       reg_write;
    logic       pc_to_addr;
    logic       reg_to_jump;
    logic       link;
    logic       reg_link;
    logic       load_imm;
    logic       pc_write;
    logic       mem_read;
    logic       mem_write;
    byte_en_t   byteenable;
    ext_op_t    ext_op;

    logic [15:0] lfsr = 16'd5867;
    int          cycle_count = 0;

    clk_gen u_clk_gen (.clk(clk));

    mips_control u_mips_control (
        .clk(clk), .reset(reset), .run(run), .waitrequest(waitrequest),
        .readdata(readdata), .addr_low(addr_low), .ir_write(ir_write),
        .alu_op(alu_op), .alu_src(alu_src), .signed_imm(signed_imm), .jump(jump),
        .branch(branch), .reg_dst(reg_dst), .mem_to_reg(mem_to_reg),
        .reg_write(reg_write), .pc_to_addr(pc_to_addr), .reg_to_jump(reg_to_jump),
        .link(link), .reg_link(reg_link), .load_imm(load_imm), .pc_write(pc_write),
        .mem_read(mem_read), .mem_write(mem_write), .byteenable(byteenable),
        .ext_op(ext_op)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int nbits, output int value);
        int k;
        value = 0;
        for (k = 0; k < nbits; k++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic word_t rtype_word(input funct_t fn);
        return {op_special, 5'd1, 5'd2, 5'd3, 5'd0, fn};
    endfunction

    function automatic word_t itype_word(input opcode_t op, input logic [15:0] imm);
        return {op, 5'd4, 5'd5, imm};
    endfunction

    function automatic word_t jtype_word(input opcode_t op, input logic [25:0] target);
        return {op, target};
    endfunction

    function automatic controls_t idle_controls();
        controls_t c;
        c = '0;
        c.alu_op = alu_add;
        c.size   = size_word;
        c.ext_op = ext_none;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic verify_controls(input controls_t e);
        check_value("alu_op", 32'(e.alu_op), 32'(alu_op));
        check_value("alu_src", 32'(e.alu_src), 32'(alu_src));
        check_value("signed_imm", 32'(e.signed_imm), 32'(signed_imm));
        check_value("jump", 32'(e.jump), 32'(jump));
        check_value("branch", 32'(e.branch), 32'(branch));
        check_value("reg_dst", 32'(e.reg_dst), 32'(reg_dst));
        check_value("mem_to_reg", 32'(e.mem_to_reg), 32'(mem_to_reg));
        check_value("reg_to_jump", 32'(e.reg_to_jump), 32'(reg_to_jump));
        check_value("link", 32'(e.link), 32'(link));
        check_value("reg_link", 32'(e.reg_link), 32'(reg_link));
        check_value("load_imm", 32'(e.load_imm), 32'(load_imm));
        check_value("ext_op", 32'(e.ext_op), 32'(ext_op));
    endtask

    task automatic expect_strobes(input logic rd, input logic wr, input logic rw,
                                  input logic pcw, input logic irw, input logic pca);
        check_value("mem_read", 32'(rd), 32'(mem_read));
        check_value("mem_write", 32'(wr), 32'(mem_write));
        check_value("reg_write", 32'(rw), 32'(reg_write));
        check_value("pc_write", 32'(pcw), 32'(pc_write));
        check_value("ir_write", 32'(irw), 32'(ir_write));
        check_value("pc_to_addr", 32'(pca), 32'(pc_to_addr));
    endtask

    // One instruction through fetch, decode, exec1 and exec2 with random stalls
    task automatic step_instruction(input word_t instr, input controls_t e,
                                    input logic from_halt, input logic keep_run);
        controls_t  idle;
        int         stall;
        int         i;
        int         r;
        logic [1:0] addr;
        logic [3:0] be;
        idle = idle_controls();
        random_bits(2, r);
        addr = 2'(r);
        if (e.is_store && e.size == size_half) begin
            addr[0] = 1'b0;                           // Halfword stores stay aligned
        end
        be = 4'b1111;
        if (e.is_store && e.size == size_byte) begin
            be = 4'b0000;
            be[addr] = 1'b1;
        end else if (e.is_store && e.size == size_half) begin
            be = 4'b0000;
            be[addr] = 1'b1;
            be[addr + 2'd1] = 1'b1;
        end
        if (from_halt) begin
            @(negedge clk);
            run = 1'b1;
            waitrequest = 1'b0;
            #1;
            expect_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        random_bits(2, stall);
        for (i = 0; i <= stall; i++) begin           // Fetch
            @(negedge clk);
            run = keep_run;
            waitrequest = (i < stall);
            readdata = instr;
            #1;
            verify_controls(idle);
            expect_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        end
        @(negedge clk);                               // Decode
        waitrequest = 1'b0;
        readdata = instr;
        #1;
        verify_controls(idle);
        expect_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        stall = 0;
        if (e.is_load) begin
            random_bits(2, stall);
        end
        for (i = 0; i <= stall; i++) begin           // Exec1
            @(negedge clk);
            waitrequest = e.is_load ? (i < stall) : 1'b1;   // A non-load must not wait
            readdata = ~instr;
            addr_low = addr;
            #1;
            verify_controls(e);
            expect_strobes(e.is_load, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            check_value("byteenable", 32'(be), 32'(byteenable));
        end
        random_bits(2, stall);
        for (i = 0; i <= stall; i++) begin           // Exec2
            @(negedge clk);
            waitrequest = (i < stall);
            #1;
            verify_controls(e);
            expect_strobes(1'b0, e.is_store, e.writes, i == stall, 1'b0, 1'b0);
            check_value("byteenable", 32'(be), 32'(byteenable));
        end
        if (!keep_run) begin
            @(negedge clk);
            waitrequest = 1'b0;
            #1;
            verify_controls(idle);
            expect_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            check_value("byteenable", 32'hf, 32'(byteenable));
        end
    endtask

    task automatic idle_after_reset();
        int i;
        run = 1'b0;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            #1;
            expect_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic back_to_back_run();
        controls_t e;
        e = idle_controls();
        e.alu_op = alu_funct;
        e.reg_dst = 1'b1;
        e.writes = 1'b1;
        step_instruction(rtype_word(fn_addu), e, 1'b1, 1'b1);   // Run stays high
        e = idle_controls();
        e.alu_op = alu_or;
        e.alu_src = 1'b1;
        e.writes = 1'b1;
        step_instruction(itype_word(op_ori, 16'h00f0), e, 1'b0, 1'b0);
    endtask

    task automatic alu_instructions();
        controls_t e;
        e = idle_controls();
        e.alu_op = alu_funct;
        e.reg_dst = 1'b1;
        e.writes = 1'b1;
        step_instruction(rtype_word(fn_subu), e, 1'b1, 1'b0);
        step_instruction(rtype_word(fn_slt), e, 1'b1, 1'b0);
        step_instruction(rtype_word(fn_sll), e, 1'b1, 1'b0);
        step_instruction(rtype_word(fn_srav), e, 1'b1, 1'b0);
        e = idle_controls();
        e.alu_src = 1'b1;
        e.writes = 1'b1;
        step_instruction(itype_word(op_addiu, 16'hfffc), e, 1'b1, 1'b0);
        e.alu_op = alu_and;
        step_instruction(itype_word(op_andi, 16'h00ff), e, 1'b1, 1'b0);
        e.alu_op = alu_xor;
        step_instruction(itype_word(op_xori, 16'h5a5a), e, 1'b1, 1'b0);
        e.alu_op = alu_slt;
        e.signed_imm = 1'b1;                          // Only SLTI extends the immediate signed
        step_instruction(itype_word(op_slti, 16'h8000), e, 1'b1, 1'b0);
        e.alu_op = alu_sltu;
        e.signed_imm = 1'b0;
        step_instruction(itype_word(op_sltiu, 16'h0010), e, 1'b1, 1'b0);
        e.alu_op = alu_add;
        e.load_imm = 1'b1;
        step_instruction(itype_word(op_lui, 16'h1234), e, 1'b1, 1'b0);
    endtask

    task automatic load_instructions();
        controls_t e;
        e = idle_controls();
        e.alu_src = 1'b1;
        e.writes = 1'b1;
        e.is_load = 1'b1;
        e.ext_op = ext_byte_s;
        step_instruction(itype_word(op_lb, 16'h0003), e, 1'b1, 1'b0);
        e.ext_op = ext_byte_u;
        step_instruction(itype_word(op_lbu, 16'h0001), e, 1'b1, 1'b0);
        e.ext_op = ext_half_s;
        step_instruction(itype_word(op_lh, 16'h0002), e, 1'b1, 1'b0);
        e.ext_op = ext_half_u;
        step_instruction(itype_word(op_lhu, 16'h0006), e, 1'b1, 1'b0);
        e.ext_op = ext_none;
        e.mem_to_reg = 1'b1;
        step_instruction(itype_word(op_lw, 16'h0008), e, 1'b1, 1'b0);
    endtask

    task automatic store_instructions();
        controls_t e;
        int        pass;
        e = idle_controls();
        e.alu_src = 1'b1;
        e.is_store = 1'b1;
        for (pass = 0; pass < 2; pass++) begin       // Two rounds for more addr_low values
            e.size = size_byte;
            step_instruction(itype_word(op_sb, 16'h0011), e, 1'b1, 1'b0);
            e.size = size_half;
            step_instruction(itype_word(op_sh, 16'h0022), e, 1'b1, 1'b0);
            e.size = size_word;
            step_instruction(itype_word(op_sw, 16'h0044), e, 1'b1, 1'b0);
        end
    endtask

    task automatic jumps_and_branches();
        controls_t e;
        e = idle_controls();
        e.jump = 1'b1;
        step_instruction(jtype_word(op_j, 26'h0000400), e, 1'b1, 1'b0);
        e.link = 1'b1;
        e.writes = 1'b1;
        step_instruction(jtype_word(op_jal, 26'h0000800), e, 1'b1, 1'b0);
        e = idle_controls();
        e.alu_op = alu_funct;
        e.reg_dst = 1'b1;
        e.jump = 1'b1;
        e.reg_to_jump = 1'b1;
        step_instruction(rtype_word(fn_jr), e, 1'b1, 1'b0);
        e.link = 1'b1;
        e.reg_link = 1'b1;
        e.writes = 1'b1;
        step_instruction(rtype_word(fn_jalr), e, 1'b1, 1'b0);
        e = idle_controls();
        e.alu_op = alu_sub_eq;
        e.branch = 1'b1;
        step_instruction(itype_word(op_beq, 16'h0004), e, 1'b1, 1'b0);
        e.alu_op = alu_ne;
        step_instruction(itype_word(op_bne, 16'hfffe), e, 1'b1, 1'b0);
        e = idle_controls();
        step_instruction(itype_word(6'd1, 16'h0004), e, 1'b1, 1'b0);    // Dropped BRANCHZ group
        step_instruction(itype_word(6'd63, 16'hffff), e, 1'b1, 1'b0);
        e.alu_op = alu_funct;
        e.reg_dst = 1'b1;
        step_instruction(rtype_word(6'd24), e, 1'b1, 1'b0);             // MULT is not kept
    endtask

    initial begin
        reset = 1'b1;
        run = 1'b0;
        waitrequest = 1'b0;
        readdata = '0;
        addr_low = 2'd0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        idle_after_reset();
        back_to_back_run();
        alu_instructions();
        load_instructions();
        store_instructions();
        jumps_and_branches();
        @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- bench/clk_gen.sv
// Testbench clock generator, free running with a period of 10 time units
module clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;                            // Half of the 10 unit period
        end
    end

endmodule

//--- hw/mips_control.sv
// Multicycle MIPS controller top joining sequencer, instruction decoder and memory lane unit
module mips_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                waitrequest,
    input  mips_isa_pkg::word_t readdata,
    input  logic [1:0]          addr_low,
    output logic                ir_write,
    output ctrl_pkg::alu_op_t   alu_op,
    output logic                alu_src,
    output logic                signed_imm,
    output logic                jump,
    output logic                branch,
    output logic                reg_dst,
    output logic                mem_to_reg,
    output logic                reg_write,
    output logic                pc_to_addr,
    output logic                reg_to_jump,
    output logic                link,
    output logic                reg_link,
    output logic                load_imm,
    output logic                pc_write,
    output logic                mem_read,
    output logic                mem_write,
    output ctrl_pkg::byte_en_t  byteenable,
    output ctrl_pkg::ext_op_t   ext_op
);

    state_if     st_bus ();
    mem_class_if mc_bus ();

    control_fsm u_control_fsm (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .waitrequest (waitrequest),
        .st          (st_bus.seq),
        .mc          (mc_bus.user),
        .pc_write    (pc_write)
    );

    instr_decoder u_instr_decoder (
        .clk         (clk),
        .reset       (reset),
        .readdata    (readdata),
        .st          (st_bus.user),
        .mc          (mc_bus.dec),
        .ir_write    (ir_write),
        .alu_op      (alu_op),
        .alu_src     (alu_src),
        .signed_imm  (signed_imm),
        .jump        (jump),
        .branch      (branch),
        .reg_dst     (reg_dst),
        .mem_to_reg  (mem_to_reg),
        .reg_write   (reg_write),
        .pc_to_addr  (pc_to_addr),
        .reg_to_jump (reg_to_jump),
        .link        (link),
        .reg_link    (reg_link),
        .load_imm    (load_imm)
    );

    mem_lane_ctrl u_mem_lane_ctrl (
        .st          (st_bus.user),
        .mc          (mc_bus.user),
        .addr_low    (addr_low),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .byteenable  (byteenable),
        .ext_op      (ext_op)
    );

endmodule

//--- hw/mem_lane_ctrl.sv
// Memory lane unit making the read/write strobes, store byte enables and load extend select
module mem_lane_ctrl (
    state_if.user               st,
    mem_class_if.user           mc,
    input  logic [1:0]          addr_low,
    output logic                mem_read,
    output logic                mem_write,
    output ctrl_pkg::byte_en_t  byteenable,
    output ctrl_pkg::ext_op_t   ext_op
);

    import ctrl_pkg::*;

    assign mem_read  = st.fetch || (st.exec1 && mc.is_load);
    assign mem_write = st.exec2 && mc.is_store;

    always_comb begin
        byteenable = '1;                                  // Full word unless a narrow store
        if (mc.is_store) begin
            case (mc.size)
                size_byte: byteenable = byte_en_t'(4'b0001 << addr_low);
                size_half: byteenable = byte_en_t'(4'b0011 << addr_low);
                default:   byteenable = '1;
            endcase
        end
    end

    always_comb begin
        ext_op = ext_none;
        if (mc.is_load) begin
            case (mc.size)
                size_byte: ext_op = mc.load_signed ? ext_byte_s : ext_byte_u;
                size_half: ext_op = mc.load_signed ? ext_half_s : ext_half_u;
                default:   ext_op = ext_none;         // LW passes the word through
            endcase
        end
    end

    always_comb begin
        if (mem_read) begin
            assert (!mem_write)
                else $error("mem_read and mem_write high together");
        end
        if (mem_write && mc.size == size_half) begin
            assert (!addr_low[0])                         // Lane pair 1:0 or 3:2
                else $error("Halfword store not aligned to a lane pair");
        end
    end

endmodule

//--- hw/instr_decoder.sv
// Instruction register and decoder producing the datapath controls
module instr_decoder (
    input  logic                clk,
    input  logic                reset,
    input  mips_isa_pkg::word_t readdata,
    state_if.user               st,
    mem_class_if.dec            mc,
    output logic                ir_write,
    output ctrl_pkg::alu_op_t   alu_op,
    output logic                alu_src,
    output logic                signed_imm,
    output logic                jump,
    output logic                branch,
    output logic                reg_dst,
    output logic                mem_to_reg,
    output logic                reg_write,
    output logic                pc_to_addr,
    output logic                reg_to_jump,
    output logic                link,
    output logic                reg_link,
    output logic                load_imm
);

    import mips_isa_pkg::*;
    import ctrl_pkg::*;

    word_t   ir;
    opcode_t opcode;
    funct_t  funct;
    logic    reg_jump;
    logic    writes_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;                                     // Zero decodes as the SLL nop
        end else if (st.decode) begin
            ir <= readdata;
        end
    end

    assign opcode   = ir[opcode_lsb +: opcode_w];
    assign funct    = ir[funct_lsb +: funct_w];
    assign reg_jump = (funct == fn_jr) || (funct == fn_jalr);

    always_comb begin
        alu_op         = alu_add;
        alu_src        = 1'b0;
        signed_imm     = 1'b0;
        jump           = 1'b0;
        branch         = 1'b0;
        reg_dst        = 1'b0;
        mem_to_reg     = 1'b0;
        reg_to_jump    = 1'b0;
        link           = 1'b0;
        reg_link       = 1'b0;
        load_imm       = 1'b0;
        writes_reg     = 1'b0;
        mc.is_load     = 1'b0;
        mc.is_store    = 1'b0;
        mc.size        = size_word;
        mc.load_signed = 1'b0;

        // Fetch, decode and halt keep the idle values above
        if (st.exec1 || st.exec2) begin
            case (opcode)
                op_special: begin
                    alu_op      = alu_funct;
                    reg_dst     = 1'b1;
                    jump        = reg_jump;
                    reg_to_jump = reg_jump;
                    link        = (funct == fn_jalr);
                    reg_link    = (funct == fn_jalr);
                    writes_reg  = is_arith_funct(funct);  // JR and unknown codes write nothing
                end
                op_addiu, op_andi, op_ori, op_xori, op_slti, op_sltiu, op_lui: begin
                    alu_src    = 1'b1;
                    writes_reg = 1'b1;
                    case (opcode)
                        op_andi:  alu_op = alu_and;
                        op_ori:   alu_op = alu_or;
                        op_xori:  alu_op = alu_xor;
                        op_slti:  alu_op = alu_slt;
                        op_sltiu: alu_op = alu_sltu;
                        default:  alu_op = alu_add;
                    endcase
                    signed_imm = (opcode == op_slti);
                    load_imm   = (opcode == op_lui);      // Immediate goes to the upper half
                end
                op_beq: begin
                    alu_op = alu_sub_eq;
                    branch = 1'b1;
                end
                op_bne: begin
                    alu_op = alu_ne;
                    branch = 1'b1;
                end
                op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
                    alu_src        = 1'b1;                // Base plus offset
                    writes_reg     = 1'b1;
                    mc.is_load     = 1'b1;
                    mc.load_signed = (opcode == op_lb) || (opcode == op_lh);
                    mem_to_reg     = (opcode == op_lw);
                    if (opcode == op_lb || opcode == op_lbu) begin
                        mc.size = size_byte;
                    end else if (opcode == op_lh || opcode == op_lhu) begin
                        mc.size = size_half;
                    end
                end
                op_sb, op_sh, op_sw: begin
                    alu_src     = 1'b1;
                    mc.is_store = 1'b1;
                    if (opcode == op_sb) begin
                        mc.size = size_byte;
                    end else if (opcode == op_sh) begin
                        mc.size = size_half;
                    end
                end
                op_j: begin
                    jump = 1'b1;
                end
                op_jal: begin
                    jump       = 1'b1;
                    link       = 1'b1;                    // Return address into r31
                    writes_reg = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    assign ir_write   = st.decode;
    assign pc_to_addr = st.fetch || st.decode;
    assign reg_write  = writes_reg && st.exec2;

    // A register write only follows a completed exec1
    a_reg_write_exec2: assert property (@(posedge clk) disable iff (reset)
        reg_write |-> $past(st.exec1 || st.exec2))
        else $error("reg_write without a completed exec1 before it");

endmodule

//--- hw/control_fsm.sv
// Control sequencer stepping halt, fetch, decode, exec1 and exec2 under the memory wait request
module control_fsm (
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  logic        waitrequest,
    state_if.seq        st,
    mem_class_if.user   mc,
    output logic        pc_write
);

    import ctrl_pkg::*;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_halt;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_halt: begin
                if (run) begin
                    state_next = st_fetch;
                end
            end
            st_fetch: begin
                if (!waitrequest) begin
                    state_next = st_decode;               // Instruction word is on readdata
                end
            end
            st_decode: begin
                state_next = st_exec1;
            end
            st_exec1: begin
                // Only a load has a read pending here
                if (!(mc.is_load && waitrequest)) begin
                    state_next = st_exec2;
                end
            end
            st_exec2: begin
                if (!waitrequest) begin
                    state_next = run ? st_fetch : st_halt;
                end
            end
            default: begin
                state_next = st_halt;
            end
        endcase
    end

    assign st.halted = (state == st_halt);
    assign st.fetch  = (state == st_fetch);
    assign st.decode = (state == st_decode);
    assign st.exec1  = (state == st_exec1);
    assign st.exec2  = (state == st_exec2);

    assign pc_write = st.exec2 && !waitrequest;           // Last cycle of the instruction

    a_state_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot({st.halted, st.fetch, st.decode, st.exec1, st.exec2}))
        else $error("Sequencer state levels are not one-hot");

    // The cycle after pc_write starts a new fetch or halts
    a_pc_write_ends: assert property (@(posedge clk) disable iff (reset)
        pc_write |=> (st.fetch || st.halted))
        else $error("No fetch or halt after the closing pc_write");

endmodule

//--- hw/ctrl_if.sv
// Controller interfaces carrying the sequencer step levels and the decoded memory class

// One level per step of the sequence
interface state_if;

    logic fetch;
    logic decode;
    logic exec1;
    logic exec2;
    logic halted;

    modport seq  (output fetch, decode, exec1, exec2, halted);
    modport user (input  fetch, decode, exec1, exec2, halted);

endinterface

// Memory access class of the instruction in the IR
interface mem_class_if;

    import ctrl_pkg::*;

    logic      is_load;
    logic      is_store;
    mem_size_t size;
    logic      load_signed;

    modport dec  (output is_load, is_store, size, load_signed);
    modport user (input  is_load, is_store, size, load_signed);

endinterface

//--- hw/ctrl_pkg.sv
// Controller package: sequencer states, ALU and extend codes, memory access size
package ctrl_pkg;

    localparam int lane_count = 4;                // Byte lanes on the 32-bit bus

    // Multicycle sequence, one step per state
    typedef enum logic [2:0] {
        st_halt   = 3'd0,
        st_fetch  = 3'd1,
        st_decode = 3'd2,
        st_exec1  = 3'd3,
        st_exec2  = 3'd4
    } state_t;

    // Operation select for the ALU control outside
    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sub_eq = 4'b0001,                     // Subtract, zero flag for BEQ
        alu_funct  = 4'b0010,                     // Take the operation from the funct field
        alu_and    = 4'b0100,
        alu_or     = 4'b0101,
        alu_xor    = 4'b0110,
        alu_slt    = 4'b0111,
        alu_ne     = 4'b1000,                     // Inequality test for BNE
        alu_sltu   = 4'b1100
    } alu_op_t;

    // Load data extension, bit 2 marks a partial load
    typedef enum logic [2:0] {
        ext_none   = 3'b000,
        ext_half_u = 3'b100,
        ext_half_s = 3'b101,
        ext_byte_u = 3'b110,
        ext_byte_s = 3'b111
    } ext_op_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef logic [lane_count-1:0] byte_en_t;

endpackage

//--- hw/mips_isa_pkg.sv
// MIPS ISA package: instruction field widths, opcodes and R-type function codes
package mips_isa_pkg;

    localparam int word_w     = 32;
    localparam int opcode_w   = 6;
    localparam int funct_w    = 6;
    localparam int opcode_lsb = 26;               // Major opcode sits in bits 31:26
    localparam int funct_lsb  = 0;                // Function field sits in bits 5:0

    typedef logic [word_w-1:0]   word_t;
    typedef logic [opcode_w-1:0] opcode_t;
    typedef logic [funct_w-1:0]  funct_t;

    localparam opcode_t op_special = 6'd0;        // R-type, function field selects
    localparam opcode_t op_j       = 6'd2;
    localparam opcode_t op_jal     = 6'd3;
    localparam opcode_t op_beq     = 6'd4;
    localparam opcode_t op_bne     = 6'd5;
    localparam opcode_t op_addiu   = 6'd9;
    localparam opcode_t op_slti    = 6'd10;
    localparam opcode_t op_sltiu   = 6'd11;
    localparam opcode_t op_andi    = 6'd12;
    localparam opcode_t op_ori     = 6'd13;
    localparam opcode_t op_xori    = 6'd14;
    localparam opcode_t op_lui     = 6'd15;
    localparam opcode_t op_lb      = 6'd32;
    localparam opcode_t op_lh      = 6'd33;
    localparam opcode_t op_lw      = 6'd35;
    localparam opcode_t op_lbu     = 6'd36;
    localparam opcode_t op_lhu     = 6'd37;
    localparam opcode_t op_sb      = 6'd40;
    localparam opcode_t op_sh      = 6'd41;
    localparam opcode_t op_sw      = 6'd43;

    localparam funct_t fn_sll  = 6'd0;
    localparam funct_t fn_srl  = 6'd2;
    localparam funct_t fn_sra  = 6'd3;
    localparam funct_t fn_sllv = 6'd4;
    localparam funct_t fn_srlv = 6'd6;
    localparam funct_t fn_srav = 6'd7;
    localparam funct_t fn_jr   = 6'd8;
    localparam funct_t fn_jalr = 6'd9;
    localparam funct_t fn_addu = 6'd33;
    localparam funct_t fn_subu = 6'd35;
    localparam funct_t fn_and  = 6'd36;
    localparam funct_t fn_or   = 6'd37;
    localparam funct_t fn_xor  = 6'd38;
    localparam funct_t fn_slt  = 6'd42;
    localparam funct_t fn_sltu = 6'd43;

    // R-type codes whose result lands in the register file
    function automatic logic is_arith_funct(funct_t f);
        case (f)
            fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav,
            fn_jalr, fn_addu, fn_subu, fn_and, fn_or, fn_xor,
            fn_slt, fn_sltu: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

endpackage
